// File: rtl/exu_cfg_pkg.sv
`default_nettype none

package exu_cfg_pkg;

   // datapath and register file geometry
   localparam int xlen = 32;
   localparam int reg_idx_w = 5;

   // shift amount taken from the low bits of operand b
   localparam int shamt_w = $clog2(xlen);

   // exception cause carried down the pipe
   localparam int exc_code_w = 6;

   // byte distance to the next instruction, for link addresses
   localparam int pc_step = 4;

   typedef logic [xlen-1:0] word_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage

`default_nettype wire

// File: rtl/exu_op_pkg.sv
`default_nettype none

package exu_op_pkg;

   import exu_cfg_pkg::*;

   // integer alu operations
   typedef enum logic [3:0] {
      alu_add    = 4'h0,
      alu_sub    = 4'h1,
      alu_slt    = 4'h2,
      alu_sltu   = 4'h3,
      alu_and    = 4'h4,
      alu_or     = 4'h5,
      alu_xor    = 4'h6,
      alu_nor    = 4'h7,
      alu_sll    = 4'h8,
      alu_srl    = 4'h9,
      alu_sra    = 4'ha,
      alu_pass_b = 4'hb   // upper-immediate loads
   } alu_op_t;

   // branch unit operations
   typedef enum logic [3:0] {
      br_beq  = 4'h0,
      br_bne  = 4'h1,
      br_blt  = 4'h2,
      br_bge  = 4'h3,
      br_bltu = 4'h4,
      br_bgeu = 4'h5,
      br_b    = 4'h6,
      br_bl   = 4'h7,
      br_jirl = 4'h8
   } bru_op_t;

   // named causes, other codes pass through unchanged
   typedef enum logic [exc_code_w-1:0] {
      exc_sys = 6'h0b,
      exc_brk = 6'h0c,
      exc_ine = 6'h0d,
      exc_ipe = 6'h0e
   } exc_code_t;

endpackage

`default_nettype wire

// File: rtl/exu_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// write-back bundle of one pipeline stage
interface exu_wb_if;

   import exu_cfg_pkg::*;

   logic     wen;
   reg_idx_t rd;
   word_t    data;
   word_t    pc;

   modport producer (output wen, rd, data, pc);
   modport consumer (input wen, rd, data, pc);

endinterface

`default_nettype wire

// File: rtl/exu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regfile (
   input  logic                  clk,
   input  logic                  reset,

   input  exu_cfg_pkg::reg_idx_t rs1,
   input  exu_cfg_pkg::reg_idx_t rs2,
   output exu_cfg_pkg::word_t    rs1_data,
   output exu_cfg_pkg::word_t    rs2_data,

   exu_wb_if.consumer            wb
);

   import exu_cfg_pkg::*;

   word_t regs [2**reg_idx_w];

   // r0 is cleared here and never written again
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 2**reg_idx_w; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wen && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // old value during a write, W forwarding covers it
   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: rtl/exu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bypass (
   input  exu_cfg_pkg::reg_idx_t rs1,
   input  exu_cfg_pkg::reg_idx_t rs2,
   input  exu_cfg_pkg::word_t    rs1_data,
   input  exu_cfg_pkg::word_t    rs2_data,

   exu_wb_if.consumer            m_bus,
   exu_wb_if.consumer            w_bus,

   output exu_cfg_pkg::word_t    rs1_fwd,
   output exu_cfg_pkg::word_t    rs2_fwd
);

   // youngest producer wins and r0 never forwards
   assign rs1_fwd = (m_bus.wen && m_bus.rd == rs1 && rs1 != '0) ? m_bus.data :
                    (w_bus.wen && w_bus.rd == rs1 && rs1 != '0) ? w_bus.data :
                    rs1_data;
   assign rs2_fwd = (m_bus.wen && m_bus.rd == rs2 && rs2 != '0) ? m_bus.data :
                    (w_bus.wen && w_bus.rd == rs2 && rs2 != '0) ? w_bus.data :
                    rs2_data;

endmodule

`default_nettype wire

// File: rtl/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
   input  exu_op_pkg::alu_op_t op,
   input  exu_cfg_pkg::word_t  a,
   input  exu_cfg_pkg::word_t  b,
   output exu_cfg_pkg::word_t  result
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   logic [shamt_w-1:0] shamt;
   logic               lt_s;
   logic               lt_u;

   assign shamt = b[shamt_w-1:0];
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;

   always_comb begin
      case (op)
         alu_add:    result = a + b;
         alu_sub:    result = a - b;
         alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
         alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
         alu_and:    result = a & b;
         alu_or:     result = a | b;
         alu_xor:    result = a ^ b;
         alu_nor:    result = ~(a | b);
         alu_sll:    result = a << shamt;
         alu_srl:    result = a >> shamt;
         // arithmetic shift keeps the sign
         alu_sra:    result = word_t'($signed(a) >>> shamt);
         alu_pass_b: result = b;
         default:    result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/exu_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
   input  logic                vld,
   input  exu_op_pkg::bru_op_t op,
   input  exu_cfg_pkg::word_t  a,
   input  exu_cfg_pkg::word_t  b,
   input  exu_cfg_pkg::word_t  pc,
   input  exu_cfg_pkg::word_t  offset,
   output logic                taken,
   output exu_cfg_pkg::word_t  target,
   output exu_cfg_pkg::word_t  link
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   logic cond;

   always_comb begin
      case (op)
         br_beq:  cond = (a == b);
         br_bne:  cond = (a != b);
         br_blt:  cond = ($signed(a) < $signed(b));
         br_bge:  cond = ($signed(a) >= $signed(b));
         br_bltu: cond = (a < b);
         br_bgeu: cond = (a >= b);
         // unconditional jumps
         br_b,
         br_bl,
         br_jirl: cond = 1'b1;
         default: cond = 1'b0;
      endcase
   end

   assign taken = vld & cond;

   // jirl is register relative, the rest pc relative
   assign target = (op == br_jirl) ? a + offset : pc + offset;

   assign link = pc + word_t'(pc_step);

endmodule

`default_nettype wire

// File: rtl/exu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exu_pipe (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  vld_d,
   input  exu_cfg_pkg::word_t    pc_d,
   input  exu_cfg_pkg::reg_idx_t rd_d,
   input  logic                  wen_d,
   input  exu_cfg_pkg::word_t    imm_d,
   input  logic                  alu_vld_d,
   input  exu_op_pkg::alu_op_t   alu_op_d,
   input  logic                  alu_a_pc_d,
   input  logic                  alu_b_imm_d,
   input  logic                  bru_vld_d,
   input  exu_op_pkg::bru_op_t   bru_op_d,
   input  exu_cfg_pkg::word_t    bru_offset_d,
   input  logic                  exc_vld_d,
   input  exu_op_pkg::exc_code_t exc_code_d,
   input  exu_cfg_pkg::reg_idx_t rs1_d,
   input  exu_cfg_pkg::reg_idx_t rs2_d,
   input  exu_cfg_pkg::word_t    rs1_data_d,
   input  exu_cfg_pkg::word_t    rs2_data_d,

   // operands toward the bypass network
   output exu_cfg_pkg::reg_idx_t rs1_e,
   output exu_cfg_pkg::reg_idx_t rs2_e,
   output exu_cfg_pkg::word_t    rs1_data_e,
   output exu_cfg_pkg::word_t    rs2_data_e,
   input  exu_cfg_pkg::word_t    rs1_fwd,
   input  exu_cfg_pkg::word_t    rs2_fwd,

   output exu_op_pkg::alu_op_t   alu_op,
   output exu_cfg_pkg::word_t    alu_a,
   output exu_cfg_pkg::word_t    alu_b,
   input  exu_cfg_pkg::word_t    alu_result,

   output logic                  bru_vld,
   output exu_op_pkg::bru_op_t   bru_op,
   output exu_cfg_pkg::word_t    bru_a,
   output exu_cfg_pkg::word_t    bru_b,
   output exu_cfg_pkg::word_t    bru_pc,
   output exu_cfg_pkg::word_t    bru_offset,
   input  logic                  bru_taken,
   input  exu_cfg_pkg::word_t    bru_target,
   input  exu_cfg_pkg::word_t    bru_link,

   exu_wb_if.producer            m_bus,
   exu_wb_if.producer            w_bus,

   output logic                  branch,
   output exu_cfg_pkg::word_t    brn_addr,
   output logic                  except,
   output exu_op_pkg::exc_code_t exc_code,
   output exu_cfg_pkg::word_t    exc_pc
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   logic      flush;
   logic      accept;
   logic      issue;
   word_t     rs1_capt;
   word_t     rs2_capt;

   logic      wen_e;
   logic      alu_vld_e;
   logic      exc_vld_e;
   logic      alu_a_pc_e;
   logic      alu_b_imm_e;
   word_t     pc_e;
   word_t     imm_e;
   reg_idx_t  rd_e;
   exc_code_t ecode_e;

   logic      wen_m;
   logic      exc_vld_m;
   logic      taken_m;
   word_t     pc_m;
   word_t     data_m;
   word_t     target_m;
   reg_idx_t  rd_m;
   exc_code_t ecode_m;

   logic      wen_w;
   logic      exc_vld_w;
   logic      taken_w;
   word_t     pc_w;
   word_t     data_w;
   word_t     target_w;
   reg_idx_t  rd_w;
   exc_code_t ecode_w;

   // any redirect still in flight kills the D instruction
   assign flush  = exc_vld_e | exc_vld_m | exc_vld_w | bru_taken | taken_m | taken_w;
   assign accept = vld_d & ~flush;
   // an exception at D keeps the units and the write quiet
   assign issue  = accept & ~exc_vld_d;

   // file is read at D, so pick up the W write of this same cycle
   assign rs1_capt = (wen_w && rd_w == rs1_d && rs1_d != '0) ? data_w : rs1_data_d;
   assign rs2_capt = (wen_w && rd_w == rs2_d && rs2_d != '0) ? data_w : rs2_data_d;

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_e     <= 1'b0;
         alu_vld_e <= 1'b0;
         bru_vld   <= 1'b0;
         exc_vld_e <= 1'b0;
         wen_m     <= 1'b0;
         exc_vld_m <= 1'b0;
         taken_m   <= 1'b0;
         wen_w     <= 1'b0;
         exc_vld_w <= 1'b0;
         taken_w   <= 1'b0;
      end else begin
         wen_e     <= issue & wen_d;
         alu_vld_e <= issue & alu_vld_d;
         bru_vld   <= issue & bru_vld_d;
         exc_vld_e <= accept & exc_vld_d;
         wen_m     <= wen_e;
         exc_vld_m <= exc_vld_e;
         taken_m   <= bru_taken;
         wen_w     <= wen_m;
         exc_vld_w <= exc_vld_m;
         taken_w   <= taken_m;
      end
   end

   always_ff @(posedge clk) begin
      // d to e
      pc_e        <= pc_d;
      rd_e        <= rd_d;
      imm_e       <= imm_d;
      alu_op      <= alu_op_d;
      alu_a_pc_e  <= alu_a_pc_d;
      alu_b_imm_e <= alu_b_imm_d;
      bru_op      <= bru_op_d;
      bru_offset  <= bru_offset_d;
      ecode_e     <= exc_code_d;
      rs1_e       <= rs1_d;
      rs2_e       <= rs2_d;
      rs1_data_e  <= rs1_capt;
      rs2_data_e  <= rs2_capt;

      // e to m, zero when no unit is active
      pc_m     <= pc_e;
      rd_m     <= rd_e;
      data_m   <= ({xlen{alu_vld_e}} & alu_result) | ({xlen{bru_vld}} & bru_link);
      target_m <= bru_target;
      ecode_m  <= ecode_e;

      // m to w
      pc_w     <= pc_m;
      rd_w     <= rd_m;
      data_w   <= data_m;
      target_w <= target_m;
      ecode_w  <= ecode_m;
   end

   assign alu_a  = alu_a_pc_e ? pc_e : rs1_fwd;
   assign alu_b  = alu_b_imm_e ? imm_e : rs2_fwd;
   assign bru_a  = rs1_fwd;
   assign bru_b  = rs2_fwd;
   assign bru_pc = pc_e;

   assign m_bus.wen  = wen_m;
   assign m_bus.rd   = rd_m;
   assign m_bus.data = data_m;
   assign m_bus.pc   = pc_m;

   assign w_bus.wen  = wen_w;
   assign w_bus.rd   = rd_w;
   assign w_bus.data = data_w;
   assign w_bus.pc   = pc_w;

   assign branch   = taken_w;
   assign brn_addr = target_w;
   assign except   = exc_vld_w;
   assign exc_code = ecode_w;
   assign exc_pc   = pc_w;

endmodule

`default_nettype wire

// File: rtl/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  vld_d,
   input  exu_cfg_pkg::word_t    pc_d,
   input  exu_cfg_pkg::reg_idx_t rs1_d,
   input  exu_cfg_pkg::reg_idx_t rs2_d,
   input  exu_cfg_pkg::reg_idx_t rd_d,
   input  logic                  wen_d,
   input  exu_cfg_pkg::word_t    imm_d,
   input  logic                  alu_vld_d,
   input  exu_op_pkg::alu_op_t   alu_op_d,
   input  logic                  alu_a_pc_d,
   input  logic                  alu_b_imm_d,
   input  logic                  bru_vld_d,
   input  exu_op_pkg::bru_op_t   bru_op_d,
   input  exu_cfg_pkg::word_t    bru_offset_d,
   input  logic                  exc_vld_d,
   input  exu_op_pkg::exc_code_t exc_code_d,

   output logic                  exu_ifu_branch,
   output exu_cfg_pkg::word_t    exu_ifu_brn_addr,
   output logic                  exu_ifu_except,
   output exu_op_pkg::exc_code_t exu_ifu_exc_code,
   output exu_cfg_pkg::word_t    exu_ifu_exc_pc,

   // retirement trace
   output logic                  commit_wen,
   output exu_cfg_pkg::reg_idx_t commit_rd,
   output exu_cfg_pkg::word_t    commit_data
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   word_t    rs1_data_d;
   word_t    rs2_data_d;
   reg_idx_t rs1_e;
   reg_idx_t rs2_e;
   word_t    rs1_data_e;
   word_t    rs2_data_e;
   word_t    rs1_fwd;
   word_t    rs2_fwd;

   alu_op_t  alu_op;
   word_t    alu_a;
   word_t    alu_b;
   word_t    alu_result;

   logic     bru_vld;
   bru_op_t  bru_op;
   word_t    bru_a;
   word_t    bru_b;
   word_t    bru_pc;
   word_t    bru_offset;
   logic     bru_taken;
   word_t    bru_target;
   word_t    bru_link;

   exu_wb_if m_bus ();
   exu_wb_if w_bus ();

   exu_regfile u_rf (
      .clk      (clk),
      .reset    (reset),
      .rs1      (rs1_d),
      .rs2      (rs2_d),
      .rs1_data (rs1_data_d),
      .rs2_data (rs2_data_d),
      .wb       (w_bus)
   );

   exu_bypass u_byp (
      .rs1      (rs1_e),
      .rs2      (rs2_e),
      .rs1_data (rs1_data_e),
      .rs2_data (rs2_data_e),
      .m_bus    (m_bus),
      .w_bus    (w_bus),
      .rs1_fwd  (rs1_fwd),
      .rs2_fwd  (rs2_fwd)
   );

   exu_alu u_alu (
      .op     (alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_result)
   );

   exu_branch u_bru (
      .vld    (bru_vld),
      .op     (bru_op),
      .a      (bru_a),
      .b      (bru_b),
      .pc     (bru_pc),
      .offset (bru_offset),
      .taken  (bru_taken),
      .target (bru_target),
      .link   (bru_link)
   );

   exu_pipe u_pipe (
      .clk          (clk),
      .reset        (reset),
      .vld_d        (vld_d),
      .pc_d         (pc_d),
      .rd_d         (rd_d),
      .wen_d        (wen_d),
      .imm_d        (imm_d),
      .alu_vld_d    (alu_vld_d),
      .alu_op_d     (alu_op_d),
      .alu_a_pc_d   (alu_a_pc_d),
      .alu_b_imm_d  (alu_b_imm_d),
      .bru_vld_d    (bru_vld_d),
      .bru_op_d     (bru_op_d),
      .bru_offset_d (bru_offset_d),
      .exc_vld_d    (exc_vld_d),
      .exc_code_d   (exc_code_d),
      .rs1_d        (rs1_d),
      .rs2_d        (rs2_d),
      .rs1_data_d   (rs1_data_d),
      .rs2_data_d   (rs2_data_d),
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .rs1_data_e   (rs1_data_e),
      .rs2_data_e   (rs2_data_e),
      .rs1_fwd      (rs1_fwd),
      .rs2_fwd      (rs2_fwd),
      .alu_op       (alu_op),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .alu_result   (alu_result),
      .bru_vld      (bru_vld),
      .bru_op       (bru_op),
      .bru_a        (bru_a),
      .bru_b        (bru_b),
      .bru_pc       (bru_pc),
      .bru_offset   (bru_offset),
      .bru_taken    (bru_taken),
      .bru_target   (bru_target),
      .bru_link     (bru_link),
      .m_bus        (m_bus),
      .w_bus        (w_bus),
      .branch       (exu_ifu_branch),
      .brn_addr     (exu_ifu_brn_addr),
      .except       (exu_ifu_except),
      .exc_code     (exu_ifu_exc_code),
      .exc_pc       (exu_ifu_exc_pc)
   );

   // commit trace is the W write-back bundle
   assign commit_wen  = w_bus.wen;
   assign commit_rd   = w_bus.rd;
   assign commit_data = w_bus.data;

endmodule

`default_nettype wire

// File: verification/exu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exu_checker (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  vld_d,
   input  exu_cfg_pkg::word_t    pc_d,
   input  exu_cfg_pkg::reg_idx_t rs1_d,
   input  exu_cfg_pkg::reg_idx_t rs2_d,
   input  exu_cfg_pkg::reg_idx_t rd_d,
   input  logic                  wen_d,
   input  exu_cfg_pkg::word_t    imm_d,
   input  logic                  alu_vld_d,
   input  exu_op_pkg::alu_op_t   alu_op_d,
   input  logic                  alu_a_pc_d,
   input  logic                  alu_b_imm_d,
   input  logic                  bru_vld_d,
   input  exu_op_pkg::bru_op_t   bru_op_d,
   input  exu_cfg_pkg::word_t    bru_offset_d,
   input  logic                  exc_vld_d,
   input  exu_op_pkg::exc_code_t exc_code_d,
   input  logic                  exu_ifu_branch,
   input  exu_cfg_pkg::word_t    exu_ifu_brn_addr,
   input  logic                  exu_ifu_except,
   input  exu_op_pkg::exc_code_t exu_ifu_exc_code,
   input  exu_cfg_pkg::word_t    exu_ifu_exc_pc,
   input  logic                  commit_wen,
   input  exu_cfg_pkg::reg_idx_t commit_rd,
   input  exu_cfg_pkg::word_t    commit_data,
   output int                    errors,
   output int                    checks,
   output int                    accepted,
   output int                    pending
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   // expected W-stage outputs of one accepted instruction
   typedef struct packed {
      logic                  busy;
      logic                  wen;
      reg_idx_t              rd;
      word_t                 data;
      logic                  taken;
      word_t                 target;
      logic                  exc;
      logic [exc_code_w-1:0] code;
      word_t                 pc;
   } expect_t;

   word_t   regs [32];
   expect_t pipe_q [$];
   expect_t nxt;
   logic    flush;

   function automatic word_t alu_expect(input alu_op_t op, input word_t a, input word_t b);
      word_t r;
      case (op)
         alu_add:    r = a + b;
         alu_sub:    r = a - b;
         alu_slt:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         alu_sltu:   r = (a < b) ? 32'd1 : 32'd0;
         alu_and:    r = a & b;
         alu_or:     r = a | b;
         alu_xor:    r = a ^ b;
         alu_nor:    r = ~(a | b);
         alu_sll:    r = a << b[4:0];
         alu_srl:    r = a >> b[4:0];
         alu_sra:    r = $signed(a) >>> b[4:0];
         alu_pass_b: r = b;
         default:    r = '0;
      endcase
      return r;
   endfunction

   function automatic logic branch_expect(input bru_op_t op, input word_t a, input word_t b);
      case (op)
         br_beq:  return a == b;
         br_bne:  return a != b;
         br_blt:  return $signed(a) < $signed(b);
         br_bge:  return $signed(a) >= $signed(b);
         br_bltu: return a < b;
         br_bgeu: return a >= b;
         default: return 1'b1;
      endcase
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_w(input expect_t ent);
      compare("commit_wen", ent.wen, commit_wen);
      if (ent.wen) begin
         compare("commit_rd", ent.rd, commit_rd);
         compare("commit_data", ent.data, commit_data);
      end
      compare("exu_ifu_branch", ent.taken, exu_ifu_branch);
      if (ent.taken) begin
         compare("exu_ifu_brn_addr", ent.target, exu_ifu_brn_addr);
      end
      compare("exu_ifu_except", ent.exc, exu_ifu_except);
      if (ent.exc) begin
         compare("exu_ifu_exc_code", ent.code, exu_ifu_exc_code);
         compare("exu_ifu_exc_pc", ent.pc, exu_ifu_exc_pc);
      end
   endtask

   // architectural effect at acceptance in program order
   task automatic execute(output expect_t ent);
      word_t a_reg;
      word_t b_reg;
      word_t op_a;
      word_t op_b;
      ent      = '0;
      ent.busy = 1'b1;
      ent.pc   = pc_d;
      if (exc_vld_d) begin
         ent.exc  = 1'b1;
         ent.code = exc_code_d;
      end else begin
         a_reg = regs[rs1_d];
         b_reg = regs[rs2_d];
         if (alu_vld_d) begin
            op_a     = alu_a_pc_d ? pc_d : a_reg;
            op_b     = alu_b_imm_d ? imm_d : b_reg;
            ent.data = alu_expect(alu_op_d, op_a, op_b);
         end
         if (bru_vld_d) begin
            ent.taken  = branch_expect(bru_op_d, a_reg, b_reg);
            ent.target = (bru_op_d == br_jirl) ? a_reg + bru_offset_d : pc_d + bru_offset_d;
            ent.data   = ent.data | (pc_d + word_t'(pc_step));
         end
         ent.wen = wen_d;
         ent.rd  = rd_d;
         if (wen_d && rd_d != '0) begin
            regs[rd_d] = ent.data;
         end
      end
   endtask

   // sampled mid cycle where inputs and outputs are settled
   always @(negedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
         end
         pipe_q.delete();
         for (int i = 0; i < 3; i++) begin
            pipe_q.push_back('0);
         end
         errors   = 0;
         checks   = 0;
         accepted = 0;
         pending  = 0;
      end else begin
         // entries 0..2 sit in W, M and E
         flush = 1'b0;
         foreach (pipe_q[i]) begin
            flush = flush | pipe_q[i].taken | pipe_q[i].exc;
         end
         check_w(pipe_q[0]);
         pipe_q.delete(0);
         nxt = '0;
         if (vld_d && !flush) begin
            execute(nxt);
            accepted++;
         end
         pipe_q.push_back(nxt);
         pending = 0;
         foreach (pipe_q[i]) begin
            pending += pipe_q[i].busy;
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu;

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   localparam int num_instr   = 2000;
   localparam int drain_limit = 10;

   logic      clk;
   logic      reset;

   logic      vld_d;
   word_t     pc_d;
   reg_idx_t  rs1_d;
   reg_idx_t  rs2_d;
   reg_idx_t  rd_d;
   logic      wen_d;
   word_t     imm_d;
   logic      alu_vld_d;
   alu_op_t   alu_op_d;
   logic      alu_a_pc_d;
   logic      alu_b_imm_d;
   logic      bru_vld_d;
   bru_op_t   bru_op_d;
   word_t     bru_offset_d;
   logic      exc_vld_d;
   exc_code_t exc_code_d;

   logic      exu_ifu_branch;
   word_t     exu_ifu_brn_addr;
   logic      exu_ifu_except;
   exc_code_t exu_ifu_exc_code;
   word_t     exu_ifu_exc_pc;
   logic      commit_wen;
   reg_idx_t  commit_rd;
   word_t     commit_data;

   int        errors;
   int        checks;
   int        accepted;
   int        pending;
   int        local_errors;
   int        waited;

   always #10 clk = ~clk;

   exu_top uut (
      .clk              (clk),
      .reset            (reset),
      .vld_d            (vld_d),
      .pc_d             (pc_d),
      .rs1_d            (rs1_d),
      .rs2_d            (rs2_d),
      .rd_d             (rd_d),
      .wen_d            (wen_d),
      .imm_d            (imm_d),
      .alu_vld_d        (alu_vld_d),
      .alu_op_d         (alu_op_d),
      .alu_a_pc_d       (alu_a_pc_d),
      .alu_b_imm_d      (alu_b_imm_d),
      .bru_vld_d        (bru_vld_d),
      .bru_op_d         (bru_op_d),
      .bru_offset_d     (bru_offset_d),
      .exc_vld_d        (exc_vld_d),
      .exc_code_d       (exc_code_d),
      .exu_ifu_branch   (exu_ifu_branch),
      .exu_ifu_brn_addr (exu_ifu_brn_addr),
      .exu_ifu_except   (exu_ifu_except),
      .exu_ifu_exc_code (exu_ifu_exc_code),
      .exu_ifu_exc_pc   (exu_ifu_exc_pc),
      .commit_wen       (commit_wen),
      .commit_rd        (commit_rd),
      .commit_data      (commit_data)
   );

   exu_checker chk (.*);

   task automatic drive_idle();
      vld_d        = 1'b0;
      pc_d         = '0;
      rs1_d        = '0;
      rs2_d        = '0;
      rd_d         = '0;
      wen_d        = 1'b0;
      imm_d        = '0;
      alu_vld_d    = 1'b0;
      alu_op_d     = alu_add;
      alu_a_pc_d   = 1'b0;
      alu_b_imm_d  = 1'b0;
      bru_vld_d    = 1'b0;
      bru_op_d     = br_beq;
      bru_offset_d = '0;
      exc_vld_d    = 1'b0;
      exc_code_d   = exc_sys;
   endtask

   task automatic drive_random();
      int unit;
      // few registers so that dependences and r0 writes are frequent
      unit         = $urandom_range(0, 9);
      vld_d        = ($urandom_range(0, 9) < 8);
      pc_d         = $urandom() & 32'hffff_fffc;
      rs1_d        = reg_idx_t'($urandom_range(0, 7));
      rs2_d        = reg_idx_t'($urandom_range(0, 7));
      rd_d         = reg_idx_t'($urandom_range(0, 7));
      wen_d        = ($urandom_range(0, 3) != 0);
      imm_d        = $urandom();
      alu_vld_d    = (unit < 6);
      alu_op_d     = alu_op_t'($urandom_range(0, 11));
      alu_a_pc_d   = $urandom_range(0, 1);
      alu_b_imm_d  = $urandom_range(0, 1);
      bru_vld_d    = (unit == 6 || unit == 7);
      bru_op_d     = bru_op_t'($urandom_range(0, 8));
      bru_offset_d = $urandom() & 32'h0000_fffc;
      exc_vld_d    = ($urandom_range(0, 99) < 3);
      // unnamed codes must pass through too
      exc_code_d   = exc_code_t'($urandom_range(0, 63));
   endtask

   initial begin
      void'($urandom(32'h839b));
      clk          = 1'b0;
      reset        = 1'b1;
      local_errors = 0;
      drive_idle();
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;

      for (int i = 0; i < num_instr; i++) begin
         @(posedge clk);
         #2;
         drive_random();
      end
      @(posedge clk);
      #2;
      drive_idle();

      // let the last instructions reach W
      waited = 0;
      while (pending != 0 && waited < drain_limit) begin
         @(posedge clk);
         waited++;
      end
      if (pending != 0) begin
         $display("timeout: %0d instructions still in the pipeline after %0d cycles",
                  pending, drain_limit);
         local_errors++;
      end
      if (accepted == 0) begin
         $display("no instruction was accepted during the run");
         local_errors++;
      end

      $display("%0d instructions accepted, %0d checks, %0d errors",
               accepted, checks, errors + local_errors);
      if (errors + local_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
rtl/exu_cfg_pkg.sv
rtl/exu_op_pkg.sv
rtl/exu_wb_if.sv
rtl/exu_regfile.sv
rtl/exu_bypass.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_pipe.sv
rtl/exu_top.sv
verification/exu_checker.sv
verification/tb_exu.sv

// File: Bender.yml
package:
  name: exu

sources:
  # design, packages first
  - rtl/exu_cfg_pkg.sv
  - rtl/exu_op_pkg.sv
  - rtl/exu_wb_if.sv
  - rtl/exu_regfile.sv
  - rtl/exu_bypass.sv
  - rtl/exu_alu.sv
  - rtl/exu_branch.sv
  - rtl/exu_pipe.sv
  - rtl/exu_top.sv

  # testbench
  - target: test
    files:
      - verification/exu_checker.sv
      - verification/tb_exu.sv
